// ==== design/busSizePkg.sv ====
// Shared types for the 68040 dynamic bus sizing bridge
// Transfer kinds, sequencer lane-state codes and the decoded cycle request
// Imported by every stage of the bridge and by the top level

`default_nettype none

package busSizePkg;

    ////////////////////////////////////////
    // Transfer classification
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        kindLong = 2'd0,                        // Long word or line
        kindWord = 2'd1,
        kindByte = 2'd2
    } xferKind_e;

    ////////////////////////////////////////
    // Sequencer states, one per lane layout
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        stIdle  = 4'd0,
        stLongA = 4'd1,                         // First or only half of a long
        stLongB = 4'd2,                         // Second half on a 16-bit port
        stWord0 = 4'd3,
        stWord2 = 4'd4,
        stByte0 = 4'd5,
        stByte1 = 4'd6,
        stByte2 = 4'd7,
        stByte3 = 4'd8
    } laneState_e;

    // Decoded CPU cycle, handed from the decoder to the sequencer
    typedef struct packed {
        xferKind_e  kind;
        logic [1:0] addr;                       // A1..A0
        logic       burst;                      // Line transfer, TT = 01
        logic       rnw;
    } cycleReq_t;

    localparam int BurstBeatsDefault = 4;       // Beats in one cache line

endpackage

`default_nettype wire

// ==== design/cycleDecode.sv ====
// First stage of the bus sizing bridge
// Samples the CPU transfer start and turns SIZ, A1..A0 and TT into a request
// reqValid is a single-cycle pulse; req holds until the next transfer start

`default_nettype none

module cycleDecode (
    input  wire                   BCLK,
    input  wire                   nRESET,
    input  wire                   nTsCpu,     // CPU transfer start, active low
    input  wire  [1:0]            size,       // SIZ1..SIZ0
    input  wire  [1:0]            addr,       // A1..A0
    input  wire  [1:0]            tt,         // Transfer type
    input  wire                   rnw,
    output logic                  reqValid,
    output busSizePkg::cycleReq_t req
);

    import busSizePkg::*;

    cycleReq_t nextReq;

    // Classify the CPU attributes
    always_comb begin
        nextReq.addr = addr;
        nextReq.rnw  = rnw;
        case (size)
            2'b10:   nextReq.kind = kindWord;
            2'b01:   nextReq.kind = kindByte;
            default: nextReq.kind = kindLong;   // 00 long, 11 line
        endcase
        nextReq.burst = (nextReq.kind == kindLong) && (tt == 2'b01);
    end

    // Start pulse, one cycle per TS
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            reqValid <= 1'b0;
        end else begin
            reqValid <= !nTsCpu;
        end
    end

    always_ff @(posedge BCLK) begin
        if (!nTsCpu) req <= nextReq;            // Held for the whole transfer
    end

    // Words must sit on an even address
    assert property (@(posedge BCLK) disable iff (!nRESET)
        (!nTsCpu && size == 2'b10) |=> !req.addr[0])
        else $error("FAIL word request at odd addr=%h", req.addr);

endmodule

`default_nettype wire

// ==== design/sizingSequencer.sv ====
// Second stage of the bus sizing bridge
// Runs the dynamic bus sizing FSM against DSACK, counts line beats and
// retimes the target and CPU strobes onto the falling BCLK edge
// BurstBeats sets the number of beats in a line transfer

`default_nettype none

module sizingSequencer #(
    parameter int BurstBeats = busSizePkg::BurstBeatsDefault
) (
    input  wire                    BCLK,
    input  wire                    nRESET,
    input  wire                    reqValid,
    input  wire busSizePkg::cycleReq_t req,
    input  wire  [1:0]             dsack,     // 00 32-bit port, 01 16-bit port
    input  wire                    nTbi,      // Burst inhibit from the target
    input  wire                    nTci,      // Cache inhibit from the target
    output busSizePkg::laneState_e state,
    output logic                   nTs,
    output logic                   nTa,
    output logic                   nTbiCpu,
    output logic                   nTciCpu
);

    import busSizePkg::*;

    localparam int CountWidth = $clog2(BurstBeats + 1);

    logic ts;                                   // Internal strobes, rising edge
    logic ta;
    logic tbi;
    logic tci;
    logic secondHalf;                           // 16-bit long needs a second run
    logic lineXfer;                             // Current long is a line
    logic burstInhibit;                         // TBI seen during this line
    logic [CountWidth-1:0] beatCount;
    logic lineDone;

    logic tsOut;                                // Falling edge copies
    logic taOut;
    logic tbiOut;
    logic tciOut;

    // A long ends at once; a line runs to BurstBeats unless inhibited
    assign lineDone = !lineXfer || burstInhibit ||
                      (beatCount == CountWidth'(BurstBeats));

    ////////////////////////////////////////
    // Bus sizing FSM
    ////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state        <= stIdle;
            ts           <= 1'b0;
            ta           <= 1'b0;
            tbi          <= 1'b0;
            tci          <= 1'b0;
            secondHalf   <= 1'b0;
            lineXfer     <= 1'b0;
            burstInhibit <= 1'b0;
            beatCount    <= '0;
        end else begin
            ts <= 1'b0;                         // Start strobe lasts one cycle
            case (state)
                stIdle: begin
                    ta           <= 1'b0;
                    tbi          <= 1'b0;
                    tci          <= 1'b0;
                    burstInhibit <= 1'b0;
                    if (reqValid) begin
                        ts <= 1'b1;
                        case (req.kind)
                            kindLong: begin
                                lineXfer  <= req.burst;
                                beatCount <= '0;
                                state     <= stLongA;
                            end
                            kindWord: state <= req.addr[1] ? stWord2 : stWord0;
                            default: begin
                                case (req.addr)
                                    2'd0:    state <= stByte0;
                                    2'd1:    state <= stByte1;
                                    2'd2:    state <= stByte2;
                                    default: state <= stByte3;
                                endcase
                            end
                        endcase
                    end
                end

                stLongA: begin
                    case (dsack)
                        2'b00: begin            // Full long word beat
                            ta           <= 1'b1;
                            tbi          <= !nTbi;
                            tci          <= !nTci;
                            burstInhibit <= burstInhibit || !nTbi;
                            if (!ta) beatCount <= beatCount + CountWidth'(1);
                        end
                        2'b01: begin            // Upper half only, no TA yet
                            secondHalf <= 1'b1;
                            if (lineXfer) tbi <= 1'b1;  // No bursts to 16-bit ports
                        end
                        2'b11: begin
                            if (secondHalf) begin
                                secondHalf <= 1'b0;
                                ts         <= 1'b1;     // Rerun TS for the lower half
                                state      <= stLongB;
                            end else if (ta) begin
                                ta  <= 1'b0;
                                tbi <= 1'b0;
                                tci <= 1'b0;
                                if (lineDone) state <= stIdle;
                            end
                        end
                        default: ;              // Byte port termination unsupported
                    endcase
                end

                default: begin                  // longB, words and bytes
                    if (dsack != 2'b11) begin
                        ta  <= 1'b1;
                        tci <= !nTci;
                    end else if (ta) begin
                        ta    <= 1'b0;
                        tbi   <= 1'b0;
                        tci   <= 1'b0;
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Strobe retiming, falling edge
    ////////////////////////////////////////

    always_ff @(negedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            tsOut  <= 1'b0;
            taOut  <= 1'b0;
            tbiOut <= 1'b0;
            tciOut <= 1'b0;
        end else begin
            tsOut  <= ts;
            taOut  <= ta;
            tbiOut <= tbi;
            tciOut <= tci;
        end
    end

    assign nTs     = !tsOut;
    assign nTa     = !taOut;
    assign nTbiCpu = !tbiOut;
    assign nTciCpu = !tciOut;

    // The CPU only starts a cycle on a free bus
    assert property (@(posedge BCLK) disable iff (!nRESET) reqValid |-> state == stIdle)
        else $error("FAIL reqValid while state=%h", state);

    assert property (@(posedge BCLK) disable iff (!nRESET) !(!nTa && !nTs))
        else $error("FAIL nTa and nTs low together");

    assert property (@(posedge BCLK) disable iff (!nRESET)
        beatCount <= CountWidth'(BurstBeats))
        else $error("FAIL beatCount=%h past line length", beatCount);

endmodule

`default_nettype wire

// ==== design/laneSteer.sv ====
// Third stage of the bus sizing bridge
// Steers CPU bytes onto the port lanes for writes, latches port bytes
// into the CPU lanes on reads, and drives both data bus enables
// Byte 0 is bits 31..24 and byte 3 is bits 7..0

`default_nettype none

module laneSteer (
    input  wire                     BCLK,
    input  wire                     nRESET,
    input  wire busSizePkg::laneState_e state,
    input  wire  [1:0]              dsack,
    input  wire                     rnw,
    input  wire                     nBg,      // Active-low bus grant
    input  wire  [31:0]             cpuDataIn,
    input  wire  [31:0]             portDataIn,
    output logic [31:0]             cpuDataOut,
    output logic [31:0]             portDataOut,
    output logic                    cpuDataOe,
    output logic                    portDataOe
);

    import busSizePkg::*;

    logic [7:0] cpuB1, cpuB2, cpuB3;            // CPU byte lanes 1 to 3
    logic [7:0] portB1, portB2, portB3;         // Port byte lanes 1 to 3

    assign {cpuB1, cpuB2, cpuB3}    = cpuDataIn[23:0];
    assign {portB1, portB2, portB3} = portDataIn[23:0];

    ////////////////////////////////////////
    // Live write path
    ////////////////////////////////////////

    always_comb begin
        case (state)
            stLongB, stWord2: portDataOut = {cpuB2, cpuB3, cpuB2, cpuB3};
            stByte1:          portDataOut = {cpuB1, cpuB1, cpuB2, cpuB3};
            stByte2:          portDataOut = {cpuB2, cpuB1, cpuB2, cpuB3};
            stByte3:          portDataOut = {cpuB3, cpuB3, cpuB3, cpuB3}; // All lanes
            default:          portDataOut = cpuDataIn;  // Idle, longA, word0, byte0
        endcase
    end

    ////////////////////////////////////////
    // Read path latched on DSACK
    ////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cpuDataOut <= '0;
        end else if (dsack != 2'b11) begin
            case (state)
                stLongA: begin
                    if (dsack == 2'b00) cpuDataOut <= portDataIn;
                    else if (dsack == 2'b01) cpuDataOut[31:16] <= portDataIn[31:16];
                end
                stLongB: cpuDataOut[15:0] <= portDataIn[31:16]; // Lower half of the long
                stWord2: cpuDataOut <= {portB2, portB3, portB2, portB3};
                stByte1: cpuDataOut <= {portB1, portB1, portB2, portB3};
                stByte2: cpuDataOut <= {portB2, portB1, portB2, portB3};
                stByte3: cpuDataOut <= {portB3, portB1, portB2, portB3};
                default: cpuDataOut <= portDataIn;  // Straight
            endcase
        end
    end

    // Enables follow the direction while the bus is granted
    assign cpuDataOe  = rnw && !nBg && nRESET;
    assign portDataOe = !rnw && !nBg && nRESET;

endmodule

`default_nettype wire

// ==== design/busSizerTop.sv ====
// Top level of the 68040 dynamic bus sizing bridge
// Chains decode, sizing sequencer and lane steering between the CPU bus
// and a target bus of 16- or 32-bit ports

`default_nettype none

module busSizerTop #(
    parameter int BurstBeats = busSizePkg::BurstBeatsDefault
) (
    input  wire         BCLK,
    input  wire         nRESET,
    input  wire         nTsCpu,
    input  wire  [1:0]  size,
    input  wire  [1:0]  addr,
    input  wire  [1:0]  tt,
    input  wire         rnw,
    input  wire  [1:0]  dsack,
    input  wire         nTbi,
    input  wire         nTci,
    input  wire         nBg,
    input  wire  [31:0] cpuDataIn,
    input  wire  [31:0] portDataIn,
    output logic        nTs,
    output logic        nTa,
    output logic        nTbiCpu,
    output logic        nTciCpu,
    output logic [31:0] cpuDataOut,
    output logic [31:0] portDataOut,
    output logic        cpuDataOe,
    output logic        portDataOe
);

    import busSizePkg::*;

    logic       reqValid;                       // Decode to sequencer
    cycleReq_t  req;
    laneState_e state;                          // Sequencer to lane steering

    cycleDecode i_decode (
        .BCLK(BCLK), .nRESET(nRESET), .nTsCpu(nTsCpu), .size(size),
        .addr(addr), .tt(tt), .rnw(rnw), .reqValid(reqValid), .req(req)
    );

    sizingSequencer #(.BurstBeats(BurstBeats)) i_seq (
        .BCLK(BCLK), .nRESET(nRESET), .reqValid(reqValid), .req(req),
        .dsack(dsack), .nTbi(nTbi), .nTci(nTci), .state(state),
        .nTs(nTs), .nTa(nTa), .nTbiCpu(nTbiCpu), .nTciCpu(nTciCpu)
    );

    laneSteer i_lanes (
        .BCLK(BCLK), .nRESET(nRESET), .state(state), .dsack(dsack),
        .rnw(rnw), .nBg(nBg), .cpuDataIn(cpuDataIn), .portDataIn(portDataIn),
        .cpuDataOut(cpuDataOut), .portDataOut(portDataOut),
        .cpuDataOe(cpuDataOe), .portDataOe(portDataOe)
    );

endmodule

`default_nettype wire

// ==== testbench/portModel.sv ====
// Behavioral target bus for the bus sizing bridge testbench
// Answers each target start strobe as a 16- or 32-bit port after a set wait,
// gives a full line of beats when bursting is allowed, drives patterned
// read data and captures the write data seen on each beat

`default_nettype none

module portModel #(
    parameter int BurstBeats = 4
) (
    input  wire         BCLK,
    input  wire         nRESET,
    input  wire         nTs,
    input  wire         width16,            // Answer as a 16-bit port
    input  wire         burst,              // Current transfer is a line
    input  wire         tbiReq,             // Assert burst inhibit
    input  wire         tciReq,             // Assert cache inhibit
    input  wire  [1:0]  waitCycles,         // 1 to 3 cycles before DSACK
    input  wire  [31:0] portDataOut,
    output logic [1:0]  dsack,
    output logic        nTbi,
    output logic        nTci,
    output logic [31:0] portDataIn,
    output logic [31:0] lastWrite
);

    int beat;                               // Running beat number, seeds the pattern
    int beatsLeft;

    // Distinct value per byte lane
    function automatic logic [31:0] readPattern(input logic [7:0] b);
        return {b ^ 8'h5A, b + 8'h11, ~b, b ^ 8'hC3};
    endfunction

    initial begin
        dsack      = 2'b11;
        nTbi       = 1'b1;
        nTci       = 1'b1;
        portDataIn = '0;
        lastWrite  = '0;
        beat       = 0;
        forever begin
            @(posedge BCLK);
            if (nRESET && !nTs) begin
                // Only an unhindered 32-bit line runs more than one beat
                beatsLeft = (burst && !width16 && !tbiReq) ? BurstBeats : 1;
                while (beatsLeft > 0) begin
                    repeat (waitCycles) @(posedge BCLK);
                    dsack      <= width16 ? 2'b01 : 2'b00;
                    nTbi       <= !tbiReq;
                    nTci       <= !tciReq;
                    portDataIn <= readPattern(8'(beat));
                    lastWrite  <= portDataOut;  // Write lanes on this beat
                    @(posedge BCLK);
                    dsack <= 2'b11;             // One cycle of DSACK
                    nTbi  <= 1'b1;
                    nTci  <= 1'b1;
                    beat      = beat + 1;
                    beatsLeft = beatsLeft - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/busSizerTb.sv ====
// Testbench for the 68040 dynamic bus sizing bridge
// Runs random long, line, word and byte transfers against a 16- or 32-bit
// port model; concurrent assertions check lanes, strobes and enables

`default_nettype none

module busSizerTb;

    import busSizePkg::*;

    localparam int BurstBeats  = BurstBeatsDefault;
    localparam int NumXfers    = 300;
    localparam int WorstCycles = 60;        // Four slow beats plus start and settle

    logic BCLK, nRESET, nTsCpu, rnw, nBg, nTbi, nTci;
    logic [1:0] size, addr, tt, dsack;
    logic [31:0] cpuDataIn, portDataIn, lastWrite;
    logic nTs, nTa, nTbiCpu, nTciCpu, cpuDataOe, portDataOe;
    logic [31:0] cpuDataOut, portDataOut;

    xferKind_e curKind = kindLong;          // Current transfer attributes
    logic [1:0] curAddr = 2'd0;
    logic [1:0] curWait = 2'd1;
    logic curRnw = 1'b1, curBurst = 1'b0, curWidth16 = 1'b0, curTbi = 1'b0, curTci = 1'b0;
    int tsTotal = 0, taTotal = 0, tsStart = 0, taStart = 0, cycleCount = 0, errorCount = 0;
    logic [31:0] lcgState = 32'd32281;
    logic [31:0] expRead, readMask, writeExp, writeMask;
    logic half2;                            // Second half of a 16-bit long

    busSizerTop #(.BurstBeats(BurstBeats)) i_dut (
        .BCLK(BCLK), .nRESET(nRESET), .nTsCpu(nTsCpu), .size(size), .addr(addr),
        .tt(tt), .rnw(rnw), .dsack(dsack), .nTbi(nTbi), .nTci(nTci), .nBg(nBg),
        .cpuDataIn(cpuDataIn), .portDataIn(portDataIn), .nTs(nTs), .nTa(nTa),
        .nTbiCpu(nTbiCpu), .nTciCpu(nTciCpu), .cpuDataOut(cpuDataOut),
        .portDataOut(portDataOut), .cpuDataOe(cpuDataOe), .portDataOe(portDataOe)
    );

    portModel #(.BurstBeats(BurstBeats)) i_port (
        .BCLK(BCLK), .nRESET(nRESET), .nTs(nTs), .width16(curWidth16), .burst(curBurst),
        .tbiReq(curTbi), .tciReq(curTci), .waitCycles(curWait), .portDataOut(portDataOut),
        .dsack(dsack), .nTbi(nTbi), .nTci(nTci), .portDataIn(portDataIn),
        .lastWrite(lastWrite)
    );

    always #5 BCLK = ~BCLK;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {lcgState[7:0], lcgState[31:8]};         // Upper state bits low
    endfunction

    function automatic logic [7:0] laneOf(input logic [31:0] w, input int n);
        return w[31 - 8*n -: 8];                         // Byte 0 is bits 31..24
    endfunction

    // Read latch rule per DSACK beat
    function automatic logic [31:0] readExpect(input xferKind_e kind, input logic [1:0] a,
                                               input logic second, input logic [1:0] ds,
                                               input logic [31:0] prev, input logic [31:0] pw);
        logic [31:0] res;
        res = prev;
        if (kind == kindLong) begin
            if (second) res[15:0] = pw[31:16];           // Lower half from port bytes 0,1
            else if (ds == 2'b01) res[31:16] = pw[31:16];
            else res = pw;
        end else if (kind == kindWord && a[1]) res[31:16] = pw[15:0];
        else if (kind == kindByte && a != 2'd0) res[31:24] = laneOf(pw, int'(a));
        else res = pw;
        return res;
    endfunction

    ////////////////////////////////////////
    // Reference model of the lanes
    ////////////////////////////////////////

    always_comb begin
        half2     = (tsTotal - tsStart) >= 2;
        writeExp  = cpuDataIn;              // Straight through
        writeMask = 32'hFFFF_FFFF;
        readMask  = 32'hFFFF_FFFF;
        if ((curKind == kindLong && half2) || (curKind == kindWord && curAddr[1])) begin
            writeExp[31:16] = cpuDataIn[15:0];
            writeMask       = 32'hFFFF_0000;
        end else if (curKind == kindByte && curAddr == 2'd3) begin
            writeExp = {4{cpuDataIn[7:0]}};             // Byte 3 on every lane
        end else if (curKind == kindByte && curAddr != 2'd0) begin
            writeExp[31:24] = laneOf(cpuDataIn, int'(curAddr));
            writeMask       = 32'hFF00_0000;
        end
        if (curKind == kindWord && curAddr[1]) readMask = 32'hFFFF_0000;
        else if (curKind == kindByte && curAddr != 2'd0) readMask = 32'hFF00_0000;
    end

    always @(posedge BCLK) begin
        cycleCount <= cycleCount + 1;
        if (!nTs) tsTotal <= tsTotal + 1;   // Each strobe spans one rising edge
        if (!nTa) taTotal <= taTotal + 1;
        if (!nRESET) expRead <= '0;
        else if (dsack != 2'b11)
            expRead <= readExpect(curKind, curAddr, half2, dsack, expRead, portDataIn);
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge BCLK) (!nRESET && cycleCount > 2) |->
        (nTs && nTa && nTbiCpu && nTciCpu && !cpuDataOe && !portDataOe))
        else begin
            errorCount++;
            $display("FAIL reset outputs nTs=%h nTa=%h nTbiCpu=%h nTciCpu=%h oe=%h%h",
                     nTs, nTa, nTbiCpu, nTciCpu, cpuDataOe, portDataOe);
        end

    assert property (@(posedge BCLK) disable iff (!nRESET)
        (!nTa && curRnw) |-> ((cpuDataOut & readMask) == (expRead & readMask)))
        else begin
            errorCount++;
            $display("FAIL cpuDataOut=%h expected %h mask %h", cpuDataOut, expRead, readMask);
        end

    assert property (@(posedge BCLK) disable iff (!nRESET)
        (dsack != 2'b11 && !curRnw) |-> ((portDataOut & writeMask) == (writeExp & writeMask)))
        else begin
            errorCount++;
            $display("FAIL portDataOut=%h expected %h mask %h", portDataOut, writeExp, writeMask);
        end

    assert property (@(posedge BCLK) disable iff (!nRESET)
        (portDataOe == (!rnw && !nBg)) && (cpuDataOe == (rnw && !nBg)))
        else begin
            errorCount++;
            $display("FAIL portDataOe=%h cpuDataOe=%h rnw=%h", portDataOe, cpuDataOe, rnw);
        end

    assert property (@(posedge BCLK) disable iff (!nRESET)
        !nTa |-> (nTbiCpu == !(curBurst && (curWidth16 || curTbi))))
        else begin
            errorCount++;
            $display("FAIL nTbiCpu=%h during nTa", nTbiCpu);
        end

    assert property (@(posedge BCLK) disable iff (!nRESET) !nTa |-> (nTciCpu == !curTci))
        else begin
            errorCount++;
            $display("FAIL nTciCpu=%h expected %h", nTciCpu, !curTci);
        end

    // One random CPU cycle, start to settled idle
    task automatic runTransfer();
        logic [31:0] r;
        xferKind_e k;
        logic [1:0] sz, ty, a, waitSel;
        logic line, inhibit;
        int expTs, expTa;
        @(posedge BCLK);
        r = nextRandom();
        case (r[3:2])
            2'd0:    begin k = kindLong; sz = 2'b00; ty = 2'b00; a = 2'd0; end
            2'd1:    begin k = kindLong; sz = 2'b11; ty = 2'b01; a = 2'd0; end  // Line
            2'd2:    begin k = kindWord; sz = 2'b10; ty = 2'b00; a = {r[4], 1'b0}; end
            default: begin k = kindByte; sz = 2'b01; ty = 2'b00; a = r[5:4]; end
        endcase
        line    = (r[3:2] == 2'd1);
        inhibit = line && r[7];
        waitSel = (r[13:12] == 2'd0) ? 2'd3 : r[13:12];
        expTs   = (k == kindLong && r[0]) ? 2 : 1;
        expTa   = (line && !r[0] && !inhibit) ? BurstBeats : 1;
        nTsCpu     <= 1'b0;
        size       <= sz;
        addr       <= a;
        tt         <= ty;
        rnw        <= r[6];
        nBg        <= r[11] & r[10];        // Bus released now and then
        cpuDataIn  <= nextRandom();
        curKind    <= k;
        curAddr    <= a;
        curRnw     <= r[6];
        curBurst   <= line;
        curWidth16 <= r[0];
        curTbi     <= inhibit;
        curTci     <= r[8];
        curWait    <= waitSel;
        tsStart    <= tsTotal;
        taStart    <= taTotal;
        @(posedge BCLK);
        nTsCpu <= 1'b1;
        while (taTotal - taStart < expTa) @(posedge BCLK);  // Watchdog bounds this
        repeat (3) @(posedge BCLK);
        assert (tsTotal - tsStart == expTs && taTotal - taStart == expTa)
            else begin
                errorCount++;
                $display("FAIL pulses nTs=%h nTa=%h expected %h %h",
                         tsTotal - tsStart, taTotal - taStart, expTs, expTa);
            end
        if (!curRnw) begin
            assert ((lastWrite & writeMask) == (writeExp & writeMask))
                else begin
                    errorCount++;
                    $display("FAIL lastWrite=%h expected %h", lastWrite, writeExp);
                end
        end
    endtask

    initial begin
        BCLK      = 1'b0;
        nRESET    = 1'b0;
        nTsCpu    = 1'b1;
        size      = 2'b00;
        addr      = 2'b00;
        tt        = 2'b00;
        rnw       = 1'b1;
        nBg       = 1'b0;
        cpuDataIn = '0;
        repeat (16) @(posedge BCLK);
        nRESET <= 1'b1;
        repeat (4) @(posedge BCLK);
        for (int i = 0; i < NumXfers; i++) runTransfer();
        $display("Summary: %0d transfers, %0d errors", NumXfers, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Hung handshake guard
    initial begin
        #((20 + NumXfers * WorstCycles) * 10);
        $display("Watchdog expired, a transfer never completed");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/busSizePkg.sv
design/cycleDecode.sv
design/sizingSequencer.sv
design/laneSteer.sv
design/busSizerTop.sv
testbench/portModel.sv
testbench/busSizerTb.sv

// ==== Makefile ====
# Verilator flow for the bus sizing bridge
TOP = busSizerTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
